// File: tb.f
src/tcb_pkg.sv
src/tcb_mem_clear_cnt.sv
src/tcb_mem_ctrl.sv
src/tcb_mem_lanes.sv
src/tcb_mem_array.sv
src/tcb_mem_top.sv
test/tcb_mem_clk.sv
test/tcb_mem_tb.sv

// File: Makefile
TOP = tcb_mem_tb

.PHONY: all lint sim clean

all: lint sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --top-module $(TOP) -GMODE=0 -f tb.f --Mdir obj_log_size -o sim
	./obj_log_size/sim > sim_log_size.log
	verilator --binary --timing --top-module $(TOP) -GMODE=1 -f tb.f --Mdir obj_byte_ena -o sim
	./obj_byte_ena/sim > sim_byte_ena.log
	cat sim_log_size.log sim_byte_ena.log
	@if grep -q '>>> FAIL' sim_log_size.log sim_byte_ena.log; then \
	  echo "simulation reported failure"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_log_size obj_byte_ena sim_log_size.log sim_byte_ena.log

// File: test/tcb_mem_tb.sv
////////////////////////////////////////
// random two-port testbench for the TCB memory against a
// byte-array model, MODE picks the lane mode
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_tb #(
  // 0 log-size lanes, 1 byte enables
  parameter int unsigned MODE = 0
);

  localparam int unsigned       SIZ = 256;
  localparam logic [1:0]        WRM = 2'b01;
  localparam tcb_pkg::tcb_mod_t MOD = (MODE == 1) ? tcb_pkg::TCB_MOD_BYTE_ENA
                                                  : tcb_pkg::TCB_MOD_LOG_SIZE;
  localparam int unsigned BEN      = tcb_pkg::BEN;
  localparam int unsigned OFW      = $clog2(BEN);
  localparam int unsigned MAW      = $clog2(SIZ);
  // clear length in cycles
  localparam int unsigned CLR      = SIZ/BEN;
  localparam int unsigned NUM_XFER = 2000;
  localparam int unsigned LIMIT    = CLR + 8 + NUM_XFER*3;
  localparam int unsigned SEED     = 96553;

  logic              tcb;
  logic              reset;
  logic              vld [2];
  tcb_pkg::tcb_req_t req [2];
  logic              rdy0;
  logic              rdy1;
  tcb_pkg::tcb_rsp_t rsp0;
  tcb_pkg::tcb_rsp_t rsp1;

  ////////////////////////////////////////
  // clock, reset and DUT
  ////////////////////////////////////////

  tcb_mem_clk #(
    .PER     (40),
    .RST_CYC (8)
  ) tcb_mem_clk_inst (
    .tcb   (tcb),
    .reset (reset)
  );

  tcb_mem_top #(
    .SIZ (SIZ),
    .MOD (MOD),
    .WRM (WRM)
  ) tcb_mem_top_inst (
    .tcb   (tcb),
    .reset (reset),
    .vld0  (vld[0]),
    .req0  (req[0]),
    .rdy0  (rdy0),
    .rsp0  (rsp0),
    .vld1  (vld[1]),
    .req1  (req[1]),
    .rdy1  (rdy1),
    .rsp1  (rsp1)
  );

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////

  // expected memory content, zero after clear
  logic [7:0]        model_mem [SIZ];
  // response due in the next cycle
  logic              pend [2];
  logic              pend_rd [2];
  tcb_pkg::tcb_rsp_t pend_rsp [2];
  // last response per port, must hold
  logic              seen [2];
  logic              seen_rd [2];
  tcb_pkg::tcb_rsp_t seen_rsp [2];
  // transfer at the coming edge
  logic              xfer [2];
  // port granted most recently, port 0 first
  logic              lst_gnt;
  logic              serving;
  // port 0 write at the previous edge
  logic              prv_wr;
  logic [15:0]       prv_adr;
  int unsigned       clr_cycles;
  int unsigned       cycle_cnt;
  int unsigned       issued;
  int unsigned       done_cnt;
  int unsigned       mismatch_cnt;
  int unsigned       fail_cnt;
  int unsigned       raw_cnt;
  int unsigned       p1_wr_cnt;
  logic              finished;

  task automatic log_mismatch(input string msg);
    mismatch_cnt++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic count_failure(input string msg);
    fail_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // random request, size aligned to the address
  function automatic tcb_pkg::tcb_req_t rand_req();
    tcb_pkg::tcb_req_t r;
    r.adr = 16'($urandom);
    r.wen = 1'($urandom);
    r.siz = 2'($urandom % 3);
    r.adr = r.adr & ~((16'd1 << r.siz) - 16'd1);
    r.ben = 4'($urandom);
    r.wdt = 32'($urandom);
    return r;
  endfunction

  // memory byte reached by request byte b, after wrap
  function automatic int unsigned lane_addr(input tcb_pkg::tcb_req_t r, input int unsigned b);
    int unsigned a;
    int unsigned base;
    a    = 32'(r.adr) % SIZ;
    base = a - (a % BEN);
    // log-size packs bytes from the address offset upward
    if (MOD == tcb_pkg::TCB_MOD_LOG_SIZE) begin
      return base + ((a % BEN + b) % BEN);
    end
    return base + b;
  endfunction

  function automatic logic lane_used(input tcb_pkg::tcb_req_t r, input int unsigned b);
    if (MOD == tcb_pkg::TCB_MOD_LOG_SIZE) begin
      return b < (32'd1 << r.siz);
    end
    return r.ben[b[OFW-1:0]];
  endfunction

  // unused bytes read as zero
  function automatic logic [31:0] expect_read(input tcb_pkg::tcb_req_t r);
    logic [BEN-1:0][7:0] d;
    d = '0;
    for (int unsigned b = 0; b < BEN; b++) begin
      if (lane_used(r, b)) d[b[OFW-1:0]] = model_mem[MAW'(lane_addr(r, b))];
    end
    return d;
  endfunction

  task automatic store_write(input tcb_pkg::tcb_req_t r);
    for (int unsigned b = 0; b < BEN; b++) begin
      if (lane_used(r, b)) model_mem[MAW'(lane_addr(r, b))] = r.wdt[b[OFW-1:0]];
    end
  endtask

  ////////////////////////////////////////
  // per-cycle checks, at the falling edge
  ////////////////////////////////////////

  task automatic check_clear(input logic [1:0] rdy);
    if (rdy == 2'b00) begin
      clr_cycles++;
    end else begin
      serving = 1'b1;
      if (clr_cycles != CLR) begin
        log_mismatch($sformatf("rdy rose after %0d clear cycles, expected %0d",
                               clr_cycles, CLR));
      end
    end
  endtask

  task automatic check_response(input logic p, input tcb_pkg::tcb_rsp_t r);
    if (pend[p]) begin
      if (r.err !== pend_rsp[p].err) begin
        log_mismatch($sformatf("port %0d err %b, expected %b", p, r.err, pend_rsp[p].err));
      end
      if (pend_rd[p] && r.rdt !== pend_rsp[p].rdt) begin
        log_mismatch($sformatf("port %0d rdt %h, expected %h", p, r.rdt, pend_rsp[p].rdt));
      end
      seen[p]     = 1'b1;
      seen_rd[p]  = pend_rd[p];
      seen_rsp[p] = pend_rsp[p];
      pend[p]     = 1'b0;
      done_cnt++;
    end else if (seen[p]) begin
      // idle port keeps its last response
      if (r.err !== seen_rsp[p].err || (seen_rd[p] && r.rdt !== seen_rsp[p].rdt)) begin
        log_mismatch($sformatf("port %0d rsp %h changed without a transfer", p, r));
      end
    end
  endtask

  task automatic check_grant(input logic [1:0] rdy);
    logic [1:0] exp;
    // tie goes to the port not granted last
    if (vld[0] && vld[1]) begin
      exp = lst_gnt ? 2'b01 : 2'b10;
    end else begin
      exp = {vld[1], vld[0]};
    end
    if (rdy !== exp) begin
      log_mismatch($sformatf("rdy %b for vld %b%b, expected %b", rdy, vld[1], vld[0], exp));
    end
  endtask

  task automatic take_transfer(input logic p, input logic rdy);
    xfer[p] = vld[p] && rdy;
    if (xfer[p]) begin
      lst_gnt         = p;
      pend[p]         = 1'b1;
      pend_rd[p]      = !req[p].wen;
      pend_rsp[p].rdt = req[p].wen ? '0 : expect_read(req[p]);
      // masked port gets an error and memory stays
      pend_rsp[p].err = req[p].wen && !WRM[p];
      if (req[p].wen && WRM[p]) store_write(req[p]);
      if (req[p].wen && p) p1_wr_cnt++;
    end
  endtask

  task automatic observe_cycle();
    if (!serving) check_clear({rdy1, rdy0});
    if (serving) begin
      check_response(1'b0, rsp0);
      check_response(1'b1, rsp1);
      check_grant({rdy1, rdy0});
      take_transfer(1'b0, rdy0);
      take_transfer(1'b1, rdy1);
      // read right after a write of the same address
      if (xfer[0] && !req[0].wen && prv_wr && req[0].adr == prv_adr) raw_cnt++;
      prv_wr  = xfer[0] && req[0].wen;
      prv_adr = req[0].adr;
    end
  endtask

  ////////////////////////////////////////
  // stimulus, at the rising edge
  ////////////////////////////////////////

  task automatic drive_port(input logic p);
    tcb_pkg::tcb_req_t r;
    if (xfer[p]) begin
      if (!p && req[p].wen && $urandom % 2 == 0 && issued < NUM_XFER) begin
        // read back the word just written
        r       = req[p];
        r.wen   = 1'b0;
        req[p] <= r;
        vld[p] <= 1'b1;
        issued++;
      end else if (issued < NUM_XFER && $urandom % 4 != 0) begin
        req[p] <= rand_req();
        vld[p] <= 1'b1;
        issued++;
      end else begin
        vld[p] <= 1'b0;
      end
    end else if (!vld[p] && issued < NUM_XFER && $urandom % 2 == 0) begin
      req[p] <= rand_req();
      vld[p] <= 1'b1;
      issued++;
    end
    // waiting request stays as it is
  endtask

  initial begin : main
    vld[0] = 1'b0;
    vld[1] = 1'b0;
    req[0] = '0;
    req[1] = '0;
    for (int unsigned i = 0; i < SIZ; i++) model_mem[i[MAW-1:0]] = 8'h00;
    pend       = '{1'b0, 1'b0};
    seen       = '{1'b0, 1'b0};
    xfer       = '{1'b0, 1'b0};
    lst_gnt    = 1'b1;
    serving    = 1'b0;
    prv_wr     = 1'b0;
    prv_adr    = '0;
    clr_cycles = 0;
    cycle_cnt  = 0;
    done_cnt   = 0;
    mismatch_cnt = 0;
    fail_cnt   = 0;
    raw_cnt    = 0;
    p1_wr_cnt  = 0;
    finished   = 1'b0;
    void'($urandom(SEED));

    // both ports wait through the clear phase
    @(posedge tcb);
    req[0] <= rand_req();
    vld[0] <= 1'b1;
    req[1] <= rand_req();
    vld[1] <= 1'b1;
    issued = 2;

    while (!finished) begin
      @(negedge tcb);
      cycle_cnt++;
      if (!reset) observe_cycle();
      if (done_cnt == NUM_XFER) begin
        finished = 1'b1;
      end else if (cycle_cnt >= LIMIT) begin
        count_failure($sformatf("timeout after %0d cycles, %0d of %0d transfers done",
                                cycle_cnt, done_cnt, NUM_XFER));
        finished = 1'b1;
      end else begin
        @(posedge tcb);
        drive_port(1'b0);
        drive_port(1'b1);
      end
    end

    // stimulus must have reached the corner cases
    if (raw_cnt == 0) count_failure("no read directly after a write of the same address");
    if (p1_wr_cnt == 0) count_failure("no write was attempted on port 1");

    $display("mode %0d: %0d transfers, %0d mismatches, %0d other errors",
             MODE, done_cnt, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tcb_mem_clk.sv
////////////////////////////////////////
// testbench clock and synchronous reset source
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_clk #(
  // clock period in ns
  parameter int unsigned PER     = 40,
  // cycles with reset high
  parameter int unsigned RST_CYC = 8
)(
  output logic tcb,
  output logic reset
);

  initial begin
    tcb = 1'b0;
    forever #(PER/2) tcb = ~tcb;
  end

  // release on a rising edge, seen low from the next edge on
  initial begin
    reset = 1'b1;
    repeat (RST_CYC) @(posedge tcb);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: src/tcb_mem_top.sv
////////////////////////////////////////
// two-port TCB memory, clears itself after reset and
// shares one array between the ports
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_top #(
  // memory size in bytes, multiple of BEN
  parameter int unsigned       SIZ = 256,
  // byte lane mode
  parameter tcb_pkg::tcb_mod_t MOD = tcb_pkg::TCB_MOD_LOG_SIZE,
  // ports allowed to write
  parameter logic [1:0]        WRM = 2'b01
)(
  input  logic              tcb,
  input  logic              reset,
  // port 0
  input  logic              vld0,
  input  tcb_pkg::tcb_req_t req0,
  output logic              rdy0,
  output tcb_pkg::tcb_rsp_t rsp0,
  // port 1
  input  logic              vld1,
  input  tcb_pkg::tcb_req_t req1,
  output logic              rdy1,
  output tcb_pkg::tcb_rsp_t rsp1
);

  localparam int unsigned WAW = $clog2(SIZ/tcb_pkg::BEN);

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////

  // clear sequence
  logic           clr_en;
  logic           clr_done;
  logic [WAW-1:0] clr_adr;

  // granted transfer
  logic              gnt;
  tcb_pkg::tcb_req_t gnt_req;
  logic              gnt_prt;
  logic              wpm;
  logic              gnt_err;

  // lane side
  logic [tcb_pkg::BEN-1:0]        lane_we;
  logic [tcb_pkg::BEN-1:0][8-1:0] lane_wdt;
  logic [WAW-1:0]                 word_adr;
  logic [tcb_pkg::BEN-1:0][8-1:0] raw_rdt;
  logic [tcb_pkg::BEN-1:0][8-1:0] rdt;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////

  tcb_mem_ctrl #(
    .WRM (WRM)
  ) tcb_mem_ctrl_inst (
    .tcb      (tcb),
    .reset    (reset),
    .vld0     (vld0),
    .vld1     (vld1),
    .req0     (req0),
    .req1     (req1),
    .clr_done (clr_done),
    .rdy0     (rdy0),
    .rdy1     (rdy1),
    .clr_en   (clr_en),
    .gnt      (gnt),
    .gnt_req  (gnt_req),
    .gnt_prt  (gnt_prt),
    .wpm      (wpm),
    .gnt_err  (gnt_err)
  );

  tcb_mem_clear_cnt #(
    .SIZ (SIZ)
  ) tcb_mem_clear_cnt_inst (
    .tcb   (tcb),
    .reset (reset),
    .en    (clr_en),
    .adr   (clr_adr),
    .done  (clr_done)
  );

  tcb_mem_lanes #(
    .SIZ (SIZ),
    .MOD (MOD)
  ) tcb_mem_lanes_inst (
    .tcb      (tcb),
    .reset    (reset),
    .gnt      (gnt),
    .gnt_req  (gnt_req),
    .wpm      (wpm),
    .raw_rdt  (raw_rdt),
    .lane_we  (lane_we),
    .lane_wdt (lane_wdt),
    .word_adr (word_adr),
    .rdt      (rdt)
  );

  // registered port index picks the rsp output
  tcb_mem_array #(
    .SIZ (SIZ)
  ) tcb_mem_array_inst (
    .tcb      (tcb),
    .reset    (reset),
    .lane_we  (lane_we),
    .lane_wdt (lane_wdt),
    .word_adr (word_adr),
    .clr_en   (clr_en),
    .clr_adr  (clr_adr),
    .gnt      (gnt),
    .gnt_prt  (gnt_prt),
    .gnt_err  (gnt_err),
    .rdt      (rdt),
    .raw_rdt  (raw_rdt),
    .rsp0     (rsp0),
    .rsp1     (rsp1)
  );

endmodule

`default_nettype wire

// File: src/tcb_mem_array.sv
////////////////////////////////////////
// byte lane storage with registered read and the per-port
// response registers
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_array #(
  // memory size in bytes
  parameter int unsigned SIZ = 256
)(
  input  logic                                  tcb,
  input  logic                                  reset,
  input  logic [tcb_pkg::BEN-1:0]               lane_we,
  input  logic [tcb_pkg::BEN-1:0][8-1:0]        lane_wdt,
  input  logic [$clog2(SIZ/tcb_pkg::BEN)-1:0]   word_adr,
  input  logic                                  clr_en,
  input  logic [$clog2(SIZ/tcb_pkg::BEN)-1:0]   clr_adr,
  input  logic                                  gnt,
  input  logic                                  gnt_prt,
  input  logic                                  gnt_err,
  // realigned read data from the lane mapper
  input  logic [tcb_pkg::BEN-1:0][8-1:0]        rdt,
  output logic [tcb_pkg::BEN-1:0][8-1:0]        raw_rdt,
  output tcb_pkg::tcb_rsp_t                     rsp0,
  output tcb_pkg::tcb_rsp_t                     rsp1
);

  // entries per lane
  localparam int unsigned DEP = SIZ/tcb_pkg::BEN;

  ////////////////////////////////////////
  // lane memories
  ////////////////////////////////////////

  for (genvar l = 0; l < tcb_pkg::BEN; l++) begin : lane
    logic [8-1:0] mem [DEP];
    logic [8-1:0] rd_q;

    // clear has priority, no port is served meanwhile
    always_ff @(posedge tcb) begin
      if (clr_en) begin
        mem[clr_adr] <= '0;
      end else if (lane_we[l]) begin
        mem[word_adr] <= lane_wdt[l];
      end
      // old data on a same-cycle write
      if (gnt) rd_q <= mem[word_adr];
    end

    assign raw_rdt[l] = rd_q;
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // response cycle flag
  logic vld_q;
  logic prt_q;
  logic err_q;

  tcb_pkg::tcb_rsp_t rsp_now;
  // last response per port
  tcb_pkg::tcb_rsp_t rsp_hld [2];

  always_ff @(posedge tcb) begin
    if (reset) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= gnt;
    end
  end

  always_ff @(posedge tcb) begin
    if (gnt) begin
      prt_q <= gnt_prt;
      err_q <= gnt_err;
    end
  end

  assign rsp_now.rdt = rdt;
  assign rsp_now.err = err_q;

  // keep the value after the response cycle
  always_ff @(posedge tcb) begin
    if (vld_q) rsp_hld[prt_q] <= rsp_now;
  end

  // live response on the transferring port only
  assign rsp0 = (vld_q && !prt_q) ? rsp_now : rsp_hld[0];
  assign rsp1 = (vld_q &&  prt_q) ? rsp_now : rsp_hld[1];

endmodule

`default_nettype wire

// File: src/tcb_mem_lanes.sv
////////////////////////////////////////
// byte lane mapping between the granted request and the
// array word, in both directions
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_lanes #(
  // memory size in bytes
  parameter int unsigned       SIZ = 256,
  // byte lane mode
  parameter tcb_pkg::tcb_mod_t MOD = tcb_pkg::TCB_MOD_LOG_SIZE
)(
  input  logic                                      tcb,
  input  logic                                      reset,
  input  logic                                      gnt,
  input  tcb_pkg::tcb_req_t                         gnt_req,
  input  logic                                      wpm,
  // registered word from the array
  input  logic [tcb_pkg::BEN-1:0][8-1:0]            raw_rdt,
  output logic [tcb_pkg::BEN-1:0]                   lane_we,
  output logic [tcb_pkg::BEN-1:0][8-1:0]            lane_wdt,
  output logic [$clog2(SIZ/tcb_pkg::BEN)-1:0]       word_adr,
  // realigned read data for the response
  output logic [tcb_pkg::BEN-1:0][8-1:0]            rdt
);

  localparam int unsigned BEN = tcb_pkg::BEN;
  localparam int unsigned AW  = tcb_pkg::AW;
  // lane offset width
  localparam int unsigned OFW = $clog2(BEN);
  // word address width
  localparam int unsigned WAW = $clog2(SIZ/BEN);
  localparam logic [AW-1:0] SIZ_A = AW'(SIZ);

  // address wrapped into the memory
  logic [AW-1:0]  adr_wrp;
  // lane rotation, zero in byte enable mode
  logic [OFW-1:0] rot;
  // lanes touched by the request
  logic [BEN-1:0] sel;

  // request fields kept for the response cycle
  logic [OFW-1:0] rot_q;
  logic [BEN-1:0] sel_q;
  logic           rd_q;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  assign adr_wrp  = gnt_req.adr % SIZ_A;
  assign word_adr = adr_wrp[OFW +: WAW];
  assign rot      = (MOD == tcb_pkg::TCB_MOD_LOG_SIZE) ? adr_wrp[OFW-1:0] : '0;

  always_comb begin
    logic [OFW-1:0] idx;
    sel      = '0;
    lane_wdt = '0;
    for (int l = 0; l < BEN; l++) begin
      // request byte landing on lane l
      idx = OFW'(l) - rot;
      lane_wdt[l] = gnt_req.wdt[idx];
      if (MOD == tcb_pkg::TCB_MOD_LOG_SIZE) begin
        // first 2**siz bytes only
        sel[l] = int'(idx) < (1 << gnt_req.siz);
      end else begin
        sel[l] = gnt_req.ben[l];
      end
    end
  end

  // no lane writes unless permitted
  assign lane_we = wpm ? sel : '0;

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      rot_q <= '0;
      sel_q <= '0;
      rd_q  <= 1'b0;
    end else if (gnt) begin
      rot_q <= rot;
      sel_q <= sel;
      rd_q  <= ~gnt_req.wen;
    end
  end

  // rotate back, zero for unselected bytes and writes
  always_comb begin
    logic [OFW-1:0] idx;
    for (int b = 0; b < BEN; b++) begin
      idx = OFW'(b) + rot_q;
      rdt[b] = (rd_q && sel_q[idx]) ? raw_rdt[idx] : 8'h00;
    end
  end

endmodule

`default_nettype wire

// File: src/tcb_mem_ctrl.sv
////////////////////////////////////////
// clear/serve FSM and round-robin arbiter for both ports,
// also decides write permission per granted port
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_ctrl #(
  // write mask, bit per port
  parameter logic [1:0] WRM = 2'b01
)(
  input  logic              tcb,
  input  logic              reset,
  // port requests
  input  logic              vld0,
  input  logic              vld1,
  input  tcb_pkg::tcb_req_t req0,
  input  tcb_pkg::tcb_req_t req1,
  // end of clear sequence
  input  logic              clr_done,
  // port back-pressure
  output logic              rdy0,
  output logic              rdy1,
  // clear counter enable
  output logic              clr_en,
  // granted transfer
  output logic              gnt,
  output tcb_pkg::tcb_req_t gnt_req,
  output logic              gnt_prt,
  output logic              wpm,
  output logic              gnt_err
);

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  tcb_pkg::mem_state_t state_q;
  tcb_pkg::mem_state_t state_d;

  // port granted most recently
  logic lst_q;
  // port selected this cycle
  logic sel;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // stay until the counter reaches the last word
      tcb_pkg::ST_CLEAR: if (clr_done) state_d = tcb_pkg::ST_SERVE;
      tcb_pkg::ST_SERVE: state_d = tcb_pkg::ST_SERVE;
      default:           state_d = tcb_pkg::ST_CLEAR;
    endcase
  end

  // lst starts at 1 so port 0 wins the first tie
  always_ff @(posedge tcb) begin
    if (reset) begin
      state_q <= tcb_pkg::ST_CLEAR;
      lst_q   <= 1'b1;
    end else begin
      state_q <= state_d;
      if (gnt) lst_q <= sel;
    end
  end

  assign clr_en = (state_q == tcb_pkg::ST_CLEAR);

  ////////////////////////////////////////
  // round-robin arbiter
  ////////////////////////////////////////

  // tie goes to the port not granted last
  assign sel = (vld0 && vld1) ? ~lst_q : vld1;

  // any request while serving is granted this cycle
  assign gnt  = (state_q == tcb_pkg::ST_SERVE) && (vld0 || vld1);
  assign rdy0 = gnt && !sel;
  assign rdy1 = gnt && sel;

  assign gnt_req = sel ? req1 : req0;
  assign gnt_prt = sel;

  ////////////////////////////////////////
  // write mask
  ////////////////////////////////////////

  // permitted write goes to the array, masked one is an error
  assign wpm     = gnt && gnt_req.wen && WRM[sel];
  assign gnt_err = gnt && gnt_req.wen && !WRM[sel];

endmodule

`default_nettype wire

// File: src/tcb_mem_clear_cnt.sv
////////////////////////////////////////
// word address counter for zeroing the array after reset
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_clear_cnt #(
  // memory size in bytes
  parameter int unsigned SIZ = 256
)(
  input  logic                                  tcb,
  input  logic                                  reset,
  input  logic                                  en,
  output logic [$clog2(SIZ/tcb_pkg::BEN)-1:0]   adr,
  output logic                                  done
);

  // word address width
  localparam int unsigned WAW = $clog2(SIZ/tcb_pkg::BEN);
  // last word index
  localparam logic [WAW-1:0] LST = WAW'(SIZ/tcb_pkg::BEN - 1);

  // walk from zero, wrap back after the last word
  always_ff @(posedge tcb) begin
    if (reset) begin
      adr <= '0;
    end else if (en) begin
      if (adr == LST) begin
        adr <= '0;
      end else begin
        adr <= adr + 1'b1;
      end
    end
  end

  // single pulse while the last word is written
  assign done = en && (adr == LST);

endmodule

`default_nettype wire

// File: src/tcb_pkg.sv
////////////////////////////////////////
// shared TCB widths, payload structs and enums for the
// two-port memory, referenced by scoped names
////////////////////////////////////////

`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // byte lanes per bus word
  localparam int unsigned BEN = 4;
  // request address width
  localparam int unsigned AW = 16;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // byte-lane mode
  typedef enum logic {
    // data packed from byte 0, siz is log2 of byte count
    TCB_MOD_LOG_SIZE,
    // data in natural lanes, ben selects bytes
    TCB_MOD_BYTE_ENA
  } tcb_mod_t;

  // controller phases
  typedef enum logic {
    // zeroing the array after reset
    ST_CLEAR,
    // arbitrating bus requests
    ST_SERVE
  } mem_state_t;

  ////////////////////////////////////////
  // payloads
  ////////////////////////////////////////

  // request, held stable by the manager until rdy
  typedef struct packed {
    logic [AW-1:0]           adr;
    // write enable
    logic                    wen;
    // log2 of byte count
    logic [1:0]              siz;
    // byte enables
    logic [BEN-1:0]          ben;
    // write data
    logic [BEN-1:0][8-1:0]   wdt;
  } tcb_req_t;

  // response, valid one cycle after the transfer
  typedef struct packed {
    // read data, unselected bytes zero
    logic [BEN-1:0][8-1:0]   rdt;
    // set for a write on a masked port
    logic                    err;
  } tcb_rsp_t;

endpackage

`default_nettype wire
